// ==== alu_subsystem.f ====
source/alu_pkg.sv
source/alu_multiplier.sv
source/alu_divider.sv
source/alu_request_in.sv
source/alu_exec.sv
source/alu_result_out.sv
source/alu_subsystem.sv
verification/alu_subsystem_tb.sv

// ==== Makefile ====
TOP = alu_subsystem_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -f alu_subsystem.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== verification/alu_stimulus.txt ====
# op src_a src_b use_immed itype_immed upper_immed curr_pc expected, all hex
00 00000005 00000007 0 00000000 00000 00000000 0000000c
00 00001000 deadbeef 1 fffffff0 00000 00000000 00000ff0
01 00000003 00000005 0 00000000 00000 00000000 fffffffe
02 00000001 0000001f 0 00000000 00000 00000000 80000000
03 ffffffff 00000001 0 00000000 00000 00000000 00000001
04 ffffffff 00000001 0 00000000 00000 00000000 00000000
05 f0f0f0f0 0ff00ff0 0 00000000 00000 00000000 ff00ff00
06 80000000 00000004 0 00000000 00000 00000000 08000000
07 80000000 00000004 0 00000000 00000 00000000 f8000000
07 f0000010 00000024 0 00000000 00000 00000000 ff000001
08 12340000 00005678 0 00000000 00000 00000000 12345678
09 ffff00ff 0f0f0f0f 0 00000000 00000 00000000 0f0f000f
0a 00000005 00000003 0 00000000 00000 00000000 00000000
0a 00000003 00000005 0 00000000 00000 00000000 ffffffff
0b 00000000 00000000 0 00000000 12345 00000000 12345000
0c 00000000 00000000 0 00000000 00001 00000100 00001100
0d 00000007 fffffffd 0 00000000 00000 00000000 ffffffeb
0d 00012345 00006789 0 00000000 00000 00000000 75cca2ed
0e 80000000 80000000 0 00000000 00000 00000000 40000000
0e fffffffe 00000003 0 00000000 00000 00000000 ffffffff
0f ffffffff ffffffff 0 00000000 00000 00000000 ffffffff
0f 00000002 80000000 0 00000000 00000 00000000 00000001
10 ffffffff ffffffff 0 00000000 00000 00000000 fffffffe
11 00000014 00000006 0 00000000 00000 00000000 00000003
11 ffffffec 00000006 0 00000000 00000 00000000 fffffffd
13 ffffffec 00000006 0 00000000 00000 00000000 fffffffe
12 ffffffec 00000006 0 00000000 00000 00000000 2aaaaaa7
14 ffffffec 00000006 0 00000000 00000 00000000 00000002
11 00000007 00000000 0 00000000 00000 00000000 ffffffff
12 00000007 00000000 0 00000000 00000 00000000 ffffffff
13 00000007 00000000 0 00000000 00000 00000000 00000007
14 fffffff9 00000000 0 00000000 00000 00000000 fffffff9
11 80000000 ffffffff 0 00000000 00000 00000000 80000000
13 80000000 ffffffff 0 00000000 00000 00000000 00000000

// ==== verification/alu_subsystem_tb.sv ====
`timescale 1ns/10ps

module alu_subsystem_tb;
    import alu_pkg::*;

    localparam int WAIT_LIMIT = 200;    // cycles per handshake wait.

    logic         clk;
    logic         reset;
    logic         in_req;
    logic         in_ack;
    alu_request_t in_data;
    logic         out_req;
    logic         out_ack;
    word_t        out_data;

    alu_request_t req_q[$];
    word_t        exp_q[$];

    int          check_count    = 0;
    int          mismatch_count = 0;
    int          protocol_count = 0;
    int          timeout_count  = 0;
    int          acks_seen      = 0;
    int          results_seen   = 0;
    logic        in_ack_prev    = 1'b0;
    logic        out_req_prev   = 1'b0;
    word_t       data_prev      = '0;
    logic [31:0] rand_state     = 32'h0b699960;

    alu_subsystem #(
        .MUL_LATENCY (2),
        .DIV_LATENCY (8)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ####################################################################
    // helpers
    // ####################################################################

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, protocol errors %0d, timeouts %0d",
                 check_count, mismatch_count, protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic report_hang(input string what);
        timeout_count++;
        $display("timeout at %0t: %s never completed", $time, what);
    endtask

    task automatic wait_in_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (in_ack !== level && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (in_ack !== level) report_hang(what);
    endtask

    task automatic wait_out_req(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (out_req !== level && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (out_req !== level) report_hang(what);
    endtask

    task automatic read_stimulus();
        int           fd;
        int           code;
        string        line;
        logic [31:0]  f_op;
        logic [31:0]  f_a;
        logic [31:0]  f_b;
        logic [31:0]  f_use;
        logic [31:0]  f_imm;
        logic [31:0]  f_upper;
        logic [31:0]  f_pc;
        logic [31:0]  f_exp;
        alu_request_t req;
        fd = $fopen("verification/alu_stimulus.txt", "r");
        if (fd == 0) begin
            protocol_count++;
            $display("could not open verification/alu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin    // skip # lines.
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   f_op, f_a, f_b, f_use, f_imm, f_upper, f_pc, f_exp);
                    if (code == 8) begin
                        req.op          = alu_op_t'(f_op[4:0]);
                        req.src_a       = f_a;
                        req.src_b       = f_b;
                        req.use_immed   = f_use[0];
                        req.itype_immed = f_imm;
                        req.upper_immed = f_upper[19:0];
                        req.curr_pc     = f_pc;
                        req_q.push_back(req);
                        exp_q.push_back(f_exp);
                    end else begin
                        protocol_count++;
                        $display("badly formed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ####################################################################
    // requester and result acceptor
    // ####################################################################

    task automatic send_requests();
        for (int i = 0; i < req_q.size() && timeout_count == 0; i++) begin
            @(posedge clk);
            in_data <= req_q[i];
            in_req  <= 1'b1;
            wait_in_ack(1'b1, $sformatf("in_ack rise for request %0d", i));
            if (timeout_count == 0) begin
                @(posedge clk);
                in_req <= 1'b0;
                wait_in_ack(1'b0, $sformatf("in_ack fall for request %0d", i));
            end
        end
    endtask

    task automatic accept_results();
        int delay;
        for (int i = 0; i < exp_q.size() && timeout_count == 0; i++) begin
            wait_out_req(1'b1, $sformatf("out_req rise for result %0d", i));
            if (timeout_count == 0) begin
                check_value($sformatf("out_data[%0d]", i), out_data, exp_q[i]);
                delay = int'((next_random() >> 16) % 32'd6);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                wait_out_req(1'b0, $sformatf("out_req fall for result %0d", i));
                if (timeout_count == 0) begin
                    @(posedge clk);
                    out_ack <= 1'b0;
                end
            end
        end
    endtask

    // handshake order and data stability checks.
    always @(negedge clk) begin
        if (reset) begin
            if (out_req === 1'b1 || in_ack === 1'b1) begin
                protocol_count++;
                $display("out_req or in_ack high during reset at %0t", $time);
            end
        end else begin
            if (in_ack === 1'b1 && !in_ack_prev) begin
                if (in_req !== 1'b1) begin
                    protocol_count++;
                    $display("in_ack rose without in_req at %0t", $time);
                end
                // capture may run one request ahead of exec, not two.
                if (acks_seen > results_seen + 1) begin
                    protocol_count++;
                    $display("in_ack for request %0d rose before result %0d was offered at %0t",
                             acks_seen, acks_seen - 2, $time);
                end
                acks_seen++;
            end
            if (out_req === 1'b1 && !out_req_prev) results_seen++;
            if (out_req === 1'b1 && out_req_prev) begin
                check_value("out_data while out_req high", out_data, data_prev);
            end
        end
        in_ack_prev  = (in_ack === 1'b1);
        out_req_prev = (out_req === 1'b1);
        data_prev    = out_data;
    end

    initial begin
        reset   = 1'b1;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        read_stimulus();
        if (req_q.size() == 0) begin
            protocol_count++;
            $display("stimulus file holds no requests");
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        fork
            send_requests();
            accept_results();
        join
        repeat (30) @(posedge clk);    // room for a stray extra result.
        check_value("result count", results_seen, exp_q.size());
        check_value("request count", acks_seen, req_q.size());
        finish_run();
    end

endmodule

// ==== source/alu_subsystem.sv ====
`timescale 1ns/10ps

module alu_subsystem #(
    parameter int MUL_LATENCY = alu_pkg::DEFAULT_MUL_LATENCY,
    parameter int DIV_LATENCY = alu_pkg::DEFAULT_DIV_LATENCY
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    output logic                  in_ack,
    input  alu_pkg::alu_request_t in_data,
    output logic                  out_req,
    input  logic                  out_ack,
    output alu_pkg::word_t        out_data
);
    import alu_pkg::*;

    // ####################################################################
    // internal links
    // ####################################################################

    logic         issue_valid;
    alu_request_t issue_op;
    logic         issue_taken;
    logic         result_valid;
    word_t        result;
    logic         result_taken;

    alu_request_in u_request_in (
        .clk         (clk),
        .reset       (reset),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .in_data     (in_data),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_taken (issue_taken)
    );

    alu_exec #(
        .MUL_LATENCY (MUL_LATENCY),
        .DIV_LATENCY (DIV_LATENCY)
    ) u_exec (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_taken  (issue_taken),
        .result_valid (result_valid),
        .result       (result),
        .result_taken (result_taken)
    );

    alu_result_out u_result_out (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .result_taken (result_taken),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data)
    );

endmodule

// ==== source/alu_result_out.sv ====
`timescale 1ns/10ps

module alu_result_out (
    input  logic           clk,
    input  logic           reset,
    input  logic           result_valid,
    input  alu_pkg::word_t result,
    output logic           result_taken,
    output logic           out_req,
    input  logic           out_ack,
    output alu_pkg::word_t out_data
);
    import alu_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_WAIT_LOW} tx_state_t;

    tx_state_t state;
    word_t     data_r;

    assign result_taken = (state == TX_IDLE) && result_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: if (result_valid) begin
                    out_req <= 1'b1;
                    state   <= TX_REQ;
                end
                TX_REQ: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= TX_WAIT_LOW;
                end
                TX_WAIT_LOW: if (!out_ack) state <= TX_IDLE;    // four-phase done.
                default: state <= TX_IDLE;
            endcase
        end
    end

    // held stable for the whole out_req high phase.
    always_ff @(posedge clk) begin
        if (result_taken) data_r <= result;
    end

    assign out_data = data_r;

endmodule

// ==== source/alu_exec.sv ====
`timescale 1ns/10ps

module alu_exec #(
    parameter int MUL_LATENCY = alu_pkg::DEFAULT_MUL_LATENCY,
    parameter int DIV_LATENCY = alu_pkg::DEFAULT_DIV_LATENCY
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  alu_pkg::alu_request_t issue_op,
    output logic                  issue_taken,
    output logic                  result_valid,
    output alu_pkg::word_t        result,
    input  logic                  result_taken
);
    import alu_pkg::*;

    localparam int MAX_LATENCY = (MUL_LATENCY > DIV_LATENCY) ? MUL_LATENCY : DIV_LATENCY;
    localparam int CNT_W       = $clog2(MAX_LATENCY + 1);

    typedef enum logic [1:0] {EX_IDLE, EX_BUSY, EX_DONE} exec_state_t;

    exec_state_t      state;
    logic [CNT_W-1:0] count;
    logic             finish;
    alu_op_t          req_op;
    word_t            req_a;
    word_t            req_b;
    word_t            result_r;
    word_t            op_b;
    word_t            upper_s;
    shamt_t           shamt;
    word_t            simple_result;
    word_t            long_result;
    logic [32:0]      mul_a;
    logic [32:0]      mul_b;
    logic [63:0]      product;
    logic             div_signed;
    logic             div_zero;
    logic             div_ovf;
    word_t            quotient;
    word_t            remainder;

    function automatic logic [CNT_W-1:0] latency_of(alu_op_t op);
        case (op)
            ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU: return CNT_W'(MUL_LATENCY);
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU:     return CNT_W'(DIV_LATENCY);
            default:                                  return '0;
        endcase
    endfunction

    // ####################################################################
    // operand select and single cycle ops
    // ####################################################################

    assign op_b    = issue_op.use_immed ? issue_op.itype_immed : issue_op.src_b;
    assign upper_s = {issue_op.upper_immed, 12'b0};
    assign shamt   = op_b[4:0];

    always_comb begin
        case (issue_op.op)
            ALU_ADD:   simple_result = issue_op.src_a + op_b;
            ALU_SUB:   simple_result = issue_op.src_a - op_b;
            ALU_SLL:   simple_result = issue_op.src_a << shamt;
            ALU_SLT:   simple_result = word_t'($signed(issue_op.src_a) < $signed(op_b));
            ALU_SLTU:  simple_result = word_t'(issue_op.src_a < op_b);
            ALU_XOR:   simple_result = issue_op.src_a ^ op_b;
            ALU_SRL:   simple_result = issue_op.src_a >> shamt;
            ALU_SRA:   simple_result = word_t'($signed(issue_op.src_a) >>> shamt);
            ALU_OR:    simple_result = issue_op.src_a | op_b;
            ALU_AND:   simple_result = issue_op.src_a & op_b;
            ALU_SUBU:  simple_result = (issue_op.src_a >= op_b) ? '0 : '1;
            ALU_LUI:   simple_result = upper_s;
            ALU_AUIPC: simple_result = upper_s + issue_op.curr_pc;
            default:   simple_result = '0;
        endcase
    end

    // mulhu zero-extends both, mulhsu only b.
    assign mul_a = {(issue_op.op == ALU_MULHU) ? 1'b0 : issue_op.src_a[31], issue_op.src_a};
    assign mul_b = {(issue_op.op inside {ALU_MULHU, ALU_MULHSU}) ? 1'b0 : op_b[31], op_b};
    assign div_signed = issue_op.op inside {ALU_DIV, ALU_REM};

    alu_multiplier #(.STAGES(MUL_LATENCY)) u_mul (
        .clk     (clk),
        .reset   (reset),
        .dataa   (mul_a),
        .datab   (mul_b),
        .product (product)
    );

    alu_divider #(.STAGES(DIV_LATENCY)) u_div (
        .clk       (clk),
        .reset     (reset),
        .numer     (issue_op.src_a),
        .denom     (op_b),
        .is_signed (div_signed),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // ####################################################################
    // multi cycle result and control
    // ####################################################################

    assign div_zero = (req_b == '0);
    assign div_ovf  = (req_a == 32'h8000_0000) && (req_b == '1);

    always_comb begin
        case (req_op)
            ALU_MUL:                          long_result = product[31:0];
            ALU_MULH, ALU_MULHSU, ALU_MULHU:  long_result = product[63:32];
            ALU_DIV:   long_result = div_zero ? '1 : (div_ovf ? req_a : quotient);
            ALU_DIVU:  long_result = div_zero ? '1 : quotient;
            ALU_REM:   long_result = div_zero ? req_a : (div_ovf ? '0 : remainder);
            ALU_REMU:  long_result = div_zero ? req_a : remainder;
            default:   long_result = '0;
        endcase
    end

    assign issue_taken  = (state == EX_IDLE) && issue_valid;
    assign finish       = (state == EX_BUSY) && (count == latency_of(req_op));
    assign result_valid = (state == EX_DONE);
    assign result       = result_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EX_IDLE;
            count <= '0;
        end else begin
            case (state)
                EX_IDLE: if (issue_valid) begin
                    count <= CNT_W'(1);
                    state <= (latency_of(issue_op.op) == '0) ? EX_DONE : EX_BUSY;
                end
                EX_BUSY: begin
                    count <= count + 1'b1;
                    if (finish) state <= EX_DONE;
                end
                EX_DONE: if (result_taken) state <= EX_IDLE;
                default: state <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_taken) begin
            req_op   <= issue_op.op;
            req_a    <= issue_op.src_a;
            req_b    <= op_b;
            result_r <= simple_result;    // replaced later for mul/div.
        end else if (finish) begin
            result_r <= long_result;
        end
    end

endmodule

// ==== source/alu_request_in.sv ====
`timescale 1ns/10ps

module alu_request_in (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    output logic                  in_ack,
    input  alu_pkg::alu_request_t in_data,
    output logic                  issue_valid,
    output alu_pkg::alu_request_t issue_op,
    input  logic                  issue_taken
);
    import alu_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_ACK, RX_STALL} rx_state_t;

    rx_state_t    state;
    alu_request_t req_r;
    logic         held;
    logic         capture;

    assign capture = (state == RX_IDLE) && in_req && !held;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= RX_IDLE;
            in_ack <= 1'b0;
            held   <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: if (capture) begin
                    in_ack <= 1'b1;
                    state  <= RX_ACK;
                end
                RX_ACK: if (!in_req) begin
                    in_ack <= 1'b0;
                    // request still waiting for exec.
                    state  <= (held && !issue_taken) ? RX_STALL : RX_IDLE;
                end
                RX_STALL: if (issue_taken) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
            if (capture) held <= 1'b1;
            else if (issue_taken) held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) req_r <= in_data;
    end

    assign issue_valid = held;
    assign issue_op    = req_r;

endmodule

// ==== source/alu_divider.sv ====
`timescale 1ns/10ps

module alu_divider #(
    parameter int STAGES = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  alu_pkg::word_t numer,
    input  alu_pkg::word_t denom,
    input  logic           is_signed,
    output alu_pkg::word_t quotient,
    output alu_pkg::word_t remainder
);
    import alu_pkg::*;

    logic  numer_neg;
    logic  denom_neg;
    word_t numer_mag;
    word_t denom_mag;
    word_t quot_mag;
    word_t rem_mag;
    word_t quot_fix;
    word_t rem_fix;
    word_t quot_pipe [STAGES];
    word_t rem_pipe  [STAGES];

    assign numer_neg = is_signed & numer[31];
    assign denom_neg = is_signed & denom[31];
    assign numer_mag = numer_neg ? -numer : numer;
    assign denom_mag = denom_neg ? -denom : denom;

    // zero divisor kept defined here, exec picks the real result.
    assign quot_mag = (denom_mag == '0) ? '0 : numer_mag / denom_mag;
    assign rem_mag  = (denom_mag == '0) ? numer_mag : numer_mag % denom_mag;

    // truncate toward zero.
    assign quot_fix = (numer_neg ^ denom_neg) ? -quot_mag : quot_mag;
    assign rem_fix  = numer_neg ? -rem_mag : rem_mag;    // sign of dividend.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < STAGES; i++) begin
                quot_pipe[i] <= '0;
                rem_pipe[i]  <= '0;
            end
        end else begin
            quot_pipe[0] <= quot_fix;
            rem_pipe[0]  <= rem_fix;
            for (int i = 1; i < STAGES; i++) begin
                quot_pipe[i] <= quot_pipe[i-1];
                rem_pipe[i]  <= rem_pipe[i-1];
            end
        end
    end

    assign quotient  = quot_pipe[STAGES-1];
    assign remainder = rem_pipe[STAGES-1];

endmodule

// ==== source/alu_multiplier.sv ====
`timescale 1ns/10ps

module alu_multiplier #(
    parameter int STAGES = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [32:0] dataa,
    input  logic [32:0] datab,
    output logic [63:0] product
);

    logic signed [65:0] full_product;
    logic [63:0]        prod_pipe [STAGES];

    // operands arrive already sign or zero extended.
    assign full_product = 66'($signed(dataa)) * 66'($signed(datab));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < STAGES; i++) begin
                prod_pipe[i] <= '0;
            end
        end else begin
            prod_pipe[0] <= full_product[63:0];
            for (int i = 1; i < STAGES; i++) begin
                prod_pipe[i] <= prod_pipe[i-1];
            end
        end
    end

    assign product = prod_pipe[STAGES-1];

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

    // ####################################################################
    // word types
    // ####################################################################

    typedef logic [31:0] word_t;
    typedef logic [19:0] upper_imm_t;
    typedef logic [4:0]  shamt_t;

    // ####################################################################
    // operation codes
    // ####################################################################

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_SUBU   = 5'd10,
        ALU_LUI    = 5'd11,
        ALU_AUIPC  = 5'd12,
        ALU_MUL    = 5'd13,
        ALU_MULH   = 5'd14,
        ALU_MULHSU = 5'd15,
        ALU_MULHU  = 5'd16,
        ALU_DIV    = 5'd17,
        ALU_DIVU   = 5'd18,
        ALU_REM    = 5'd19,
        ALU_REMU   = 5'd20,
        ALU_NOP    = 5'd21
    } alu_op_t;

    typedef struct packed {
        alu_op_t    op;
        word_t      src_a;
        word_t      src_b;
        logic       use_immed;     // select itype_immed over src_b.
        word_t      itype_immed;
        upper_imm_t upper_immed;
        word_t      curr_pc;
    } alu_request_t;

    localparam int DEFAULT_MUL_LATENCY = 2;
    localparam int DEFAULT_DIV_LATENCY = 8;

endpackage
